// File: include/fma_fp16_config.svh
// width, bias and threshold macros for the FP16 FMA, included by the package and the RTL
`ifndef FMA_FP16_CONFIG_SVH
`define FMA_FP16_CONFIG_SVH

// FP16 format
`define FP_EXP_BIAS     15
`define FP_MIN_EXP      (-14)   // exponent of subnormals
`define FP_MAN_W        11      // mantissa incl. hidden bit
`define FP_EXP_W        6       // signed internal exponent

// datapath widths
`define PP_ROW_W        24      // one Booth row
`define PROD_W          22      // mantissa product
`define SUM_W           35      // aligned sum

// beyond this lead of c the product cannot touch the result
`define FAR_LEFT_LIMIT  13

`endif

// File: design/fma_fp16_pkg.sv
// shared structs and enums for the FP16 FMA stages, imported by every RTL module
`include "fma_fp16_config.svh"

package fma_fp16_pkg;

    typedef struct packed {
        logic                       sign;
        logic [4:0]                 exponent;
        logic [`FP_MAN_W-2:0]       fraction;
    } fp16_t;

    typedef struct packed {
        logic                       sign;
        logic signed [`FP_EXP_W-1:0] exponent;  // unbiased
        logic [`FP_MAN_W-1:0]       mantissa;   // hidden bit included
    } operand_t;

    typedef struct packed {
        logic                       sign_ab;
        logic signed [`FP_EXP_W-1:0] exp_ab;    // exp_a + exp_b
        operand_t                   c;
        logic signed [`FP_EXP_W-1:0] exp_diff;  // exp_c - exp_ab wrapped to 6 bits
    } decoded_t;

    typedef enum logic [3:0] {
        DIGIT_ZERO,
        DIGIT_POS1,
        DIGIT_POS2,
        DIGIT_POS3,
        DIGIT_POS4,
        DIGIT_NEG1,
        DIGIT_NEG2,
        DIGIT_NEG3,
        DIGIT_NEG4
    } booth_digit_e;

    // negatives are one's complements, the +1 goes into the next row
    typedef struct packed {
        logic [`FP_MAN_W:0]         pos1;
        logic [`FP_MAN_W:0]         neg1;
        logic [`FP_MAN_W+1:0]       pos2;
        logic [`FP_MAN_W+1:0]       neg2;
        logic [`FP_MAN_W+2:0]       pos3;
        logic [`FP_MAN_W+2:0]       neg3;
        logic [`FP_MAN_W+2:0]       pos4;
        logic [`FP_MAN_W+2:0]       neg4;
    } multiples_t;

    typedef logic [3:0][`PP_ROW_W-1:0] pp_rows_t;

    typedef struct packed {
        logic [`SUM_W-1:0]          magnitude;
        logic                       sign;
        logic signed [`FP_EXP_W-1:0] exp_ab;
        logic signed [`FP_EXP_W-1:0] exp_diff;
        logic                       far_left;
        logic [`FP_MAN_W-1:0]       man_c;
    } sum_stage_t;

endpackage

// File: design/operand_decode.sv
// splits a, b and c into sign, unbiased exponent and mantissa, and forms the product exponent
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module operand_decode
    import fma_fp16_pkg::*;
(
    input  fp16_t                   a,
    input  fp16_t                   b,
    input  fp16_t                   c,
    output decoded_t                decoded,
    output logic [`FP_MAN_W-1:0]    mantissa_a,
    output logic [`FP_MAN_W-1:0]    mantissa_b
);

    function automatic operand_t unpack(input fp16_t x);
        operand_t op;
        op.sign = x.sign;
        if (x.exponent == '0) begin // zero or subnormal, no hidden bit
            op.exponent = `FP_EXP_W'(`FP_MIN_EXP);
            op.mantissa = {1'b0, x.fraction};
        end else begin
            op.exponent = `FP_EXP_W'(x.exponent) - `FP_EXP_W'(`FP_EXP_BIAS);
            op.mantissa = {1'b1, x.fraction};
        end
        return op;
    endfunction

    operand_t op_a;
    operand_t op_b;

    assign op_a       = unpack(a);
    assign op_b       = unpack(b);
    assign mantissa_a = op_a.mantissa;
    assign mantissa_b = op_b.mantissa;

    always_comb begin
        decoded.sign_ab  = op_a.sign ^ op_b.sign;
        decoded.exp_ab   = op_a.exponent + op_b.exponent; // bias removed, fits -28..30
        decoded.c        = unpack(c);
        decoded.exp_diff = decoded.c.exponent - decoded.exp_ab; // sets the alignment of c
    end

endmodule

// File: design/booth8_pp_gen.sv
// radix-8 Booth recoding of mantissa_b into four partial-product rows of mantissa_a
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module booth8_pp_gen
    import fma_fp16_pkg::*;
(
    input  logic [`FP_MAN_W-1:0]    mantissa_a,
    input  logic [`FP_MAN_W-1:0]    mantissa_b,
    output pp_rows_t                rows
);

    function automatic booth_digit_e recode(input logic [3:0] window);
        case (window)
            4'b0001, 4'b0010: return DIGIT_POS1;
            4'b0011, 4'b0100: return DIGIT_POS2;
            4'b0101, 4'b0110: return DIGIT_POS3;
            4'b0111:          return DIGIT_POS4;
            4'b1000:          return DIGIT_NEG4;
            4'b1001, 4'b1010: return DIGIT_NEG3;
            4'b1011, 4'b1100: return DIGIT_NEG2;
            4'b1101, 4'b1110: return DIGIT_NEG1;
            default:          return DIGIT_ZERO; // 0000 and 1111
        endcase
    endfunction

    // all multiples are sign extended, the positive ones have a zero msb
    function automatic logic [`PP_ROW_W-1:0] pick_multiple(input booth_digit_e digit,
                                                           input multiples_t m);
        case (digit)
            DIGIT_POS1: return `PP_ROW_W'($signed(m.pos1));
            DIGIT_POS2: return `PP_ROW_W'($signed(m.pos2));
            DIGIT_POS3: return `PP_ROW_W'($signed(m.pos3));
            DIGIT_POS4: return `PP_ROW_W'($signed(m.pos4));
            DIGIT_NEG1: return `PP_ROW_W'($signed(m.neg1));
            DIGIT_NEG2: return `PP_ROW_W'($signed(m.neg2));
            DIGIT_NEG3: return `PP_ROW_W'($signed(m.neg3));
            DIGIT_NEG4: return `PP_ROW_W'($signed(m.neg4));
            default:    return '0;
        endcase
    endfunction

    multiples_t            mult;
    booth_digit_e          digit [4];
    logic [`FP_MAN_W+1:0]  b_ext; // b with a zero below the lsb and above the msb

    always_comb begin
        mult.pos1 = {1'b0, mantissa_a};
        mult.pos2 = {1'b0, mantissa_a, 1'b0};
        mult.pos3 = {2'b0, mult.pos1} + {1'b0, mult.pos2};
        mult.pos4 = {1'b0, mantissa_a, 2'b0};
        mult.neg1 = ~mult.pos1;
        mult.neg2 = ~mult.pos2;
        mult.neg3 = ~mult.pos3;
        mult.neg4 = ~mult.pos4;
    end

    assign b_ext = {1'b0, mantissa_b, 1'b0};

    // top window is {0, b10, b9, b8} so row 3 is never negative
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            digit[i] = recode(b_ext[3*i +: 4]);
        end
        for (int i = 0; i < 4; i++) begin
            rows[i] = pick_multiple(digit[i], mult) << (3 * i);
            if (i > 0) begin // free low bit takes the +1 of the row below
                rows[i][3*i-3] = digit[i-1] inside {DIGIT_NEG1, DIGIT_NEG2, DIGIT_NEG3, DIGIT_NEG4};
            end
        end
    end

endmodule

// File: design/csa_reduce.sv
// carry-save reduction of the four Booth rows and final add to the mantissa product
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module csa_reduce
    import fma_fp16_pkg::*;
(
    input  pp_rows_t                rows,
    output logic [`PROD_W-1:0]      mantissa_product
);

    // 3:2 compressor, [0] is sum and [1] the shifted carry
    function automatic logic [1:0][`PP_ROW_W-1:0] compress(input logic [`PP_ROW_W-1:0] x,
                                                          input logic [`PP_ROW_W-1:0] y,
                                                          input logic [`PP_ROW_W-1:0] z);
        logic [1:0][`PP_ROW_W-1:0] vec;
        vec[0] = x ^ y ^ z;
        vec[1] = ((x & y) | (y & z) | (x & z)) << 1;
        return vec;
    endfunction

    logic [1:0][`PP_ROW_W-1:0]  level1;
    logic [1:0][`PP_ROW_W-1:0]  level2;
    logic [`PP_ROW_W-1:0]       total;

    assign level1 = compress(rows[0], rows[1], rows[2]);
    assign level2 = compress(level1[0], level1[1], rows[3]);
    assign total  = level2[0] + level2[1]; // sign extensions wrap out above bit 23

    assign mantissa_product = total[`PROD_W-1:0];

endmodule

// File: design/addend_align.sv
// aligns c's mantissa to the product and adds or subtracts it, giving sign and magnitude
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module addend_align
    import fma_fp16_pkg::*;
(
    input  decoded_t                decoded,
    input  logic [`PROD_W-1:0]      mantissa_product,
    output sum_stage_t              sum_stage
);

    localparam int EXT_W = `SUM_W - 1;

    logic                   diff_neg;
    logic [`FP_EXP_W:0]     diff_full;
    logic [`FP_EXP_W:0]     shift_amt;
    logic                   far_left;
    logic [EXT_W-1:0]       ext_man_c;
    logic [EXT_W-1:0]       shifted_c;
    logic                   subtract;
    logic [`SUM_W-1:0]      addend;
    logic [`SUM_W-1:0]      raw_sum;
    logic                   sum_neg;

    // the real difference spans +-44, so its 7th bit comes from comparing exponents
    assign diff_neg  = decoded.c.exponent < decoded.exp_ab;
    assign diff_full = {diff_neg, decoded.exp_diff};
    assign shift_amt = diff_neg ? -diff_full : diff_full;
    assign far_left  = !diff_neg && (shift_amt > `FAR_LEFT_LIMIT);

    // lsb of c's mantissa sits at product weight 2^-10
    assign ext_man_c = EXT_W'(decoded.c.mantissa) << (`FP_MAN_W - 1);
    assign shifted_c = diff_neg ? (ext_man_c >> shift_amt) : (ext_man_c << shift_amt);

    assign subtract = decoded.c.sign ^ decoded.sign_ab;
    assign addend   = subtract ? ~{1'b0, shifted_c} : {1'b0, shifted_c};
    assign raw_sum  = addend + `SUM_W'(mantissa_product) + `SUM_W'(subtract); // carry-in
    assign sum_neg  = raw_sum[`SUM_W-1]; // c outweighs the product

    always_comb begin
        sum_stage.magnitude = sum_neg ? -raw_sum : raw_sum;
        sum_stage.sign      = far_left ? decoded.c.sign : (decoded.sign_ab ^ sum_neg);
        sum_stage.exp_ab    = decoded.exp_ab;
        sum_stage.exp_diff  = decoded.exp_diff;
        sum_stage.far_left  = far_left;
        sum_stage.man_c     = decoded.c.mantissa;
    end

endmodule

// File: design/lzc_normalize.sv
// leading-zero count and normalizing shift of the sum, clamped at the subnormal exponent
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module lzc_normalize
    import fma_fp16_pkg::*;
(
    input  sum_stage_t                  sum_stage,
    output logic [`SUM_W-1:0]           normalized,
    output logic signed [`FP_EXP_W-1:0] exp_offset
);

    // msb of the sum relative to the product binary point
    localparam int NORM_POS = `SUM_W - 1 - 2 * (`FP_MAN_W - 1);
    localparam int EXP_IW   = `FP_EXP_W + 2;

    logic [5:0]                 lz;
    logic signed [EXP_IW-1:0]   exp_natural;
    logic                       clamp;
    logic [5:0]                 shift;

    // highest set bit wins, an all-zero sum counts SUM_W
    always_comb begin
        lz = 6'(`SUM_W);
        for (int i = 0; i < `SUM_W; i++) begin
            if (sum_stage.magnitude[i]) begin
                lz = 6'(`SUM_W - 1 - i);
            end
        end
    end

    assign exp_natural = EXP_IW'(sum_stage.exp_ab) + EXP_IW'(NORM_POS) - EXP_IW'(lz);
    assign clamp       = exp_natural < `FP_MIN_EXP;

    // when clamped the result stays at FP_MIN_EXP and keeps leading zeros
    always_comb begin
        if (clamp) begin
            exp_offset = `FP_EXP_W'(`FP_MIN_EXP - sum_stage.exp_ab);
        end else begin
            exp_offset = `FP_EXP_W'(NORM_POS - lz);
        end
    end

    assign shift      = 6'(NORM_POS - exp_offset); // equals lz when not clamped
    assign normalized = sum_stage.magnitude << shift;

endmodule

// File: design/round_pack.sv
// round-to-nearest-even of the normalized sum and packing into an FP16 result
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module round_pack
    import fma_fp16_pkg::*;
(
    input  sum_stage_t                  sum_stage,
    input  logic [`SUM_W-1:0]           normalized,
    input  logic signed [`FP_EXP_W-1:0] exp_offset,
    output fp16_t                       result
);

    localparam int MAN_LSB = `SUM_W - `FP_MAN_W;
    localparam int EXP_IW  = `FP_EXP_W + 2;

    logic [`FP_MAN_W-1:0]           man;
    logic                           guard;
    logic                           round_bit;
    logic                           sticky;
    logic                           round_up;
    logic [`FP_MAN_W:0]             man_inc;
    logic [`FP_MAN_W-1:0]           man_rounded;
    logic signed [`FP_EXP_W-1:0]    exp_c;
    logic signed [EXP_IW-1:0]       exp_unbiased;
    logic [EXP_IW-1:0]              exp_biased;

    // far-left passes c through untouched
    assign man       = sum_stage.far_left ? sum_stage.man_c : normalized[`SUM_W-1:MAN_LSB];
    assign guard     = !sum_stage.far_left && normalized[MAN_LSB-1];
    assign round_bit = !sum_stage.far_left && normalized[MAN_LSB-2];
    assign sticky    = !sum_stage.far_left && (|normalized[MAN_LSB-3:0]);

    assign round_up    = guard && (round_bit || sticky || man[0]); // ties go to even
    assign man_inc     = {1'b0, man} + (`FP_MAN_W+1)'(round_up);
    assign man_rounded = man_inc[`FP_MAN_W] ? {1'b1, {(`FP_MAN_W-1){1'b0}}}
                                            : man_inc[`FP_MAN_W-1:0];

    assign exp_c = sum_stage.exp_ab + sum_stage.exp_diff; // the 6-bit wrap cancels here

    always_comb begin
        if (sum_stage.far_left) begin
            exp_unbiased = EXP_IW'(exp_c);
        end else begin
            exp_unbiased = EXP_IW'(sum_stage.exp_ab) + EXP_IW'(exp_offset);
        end
        exp_unbiased = exp_unbiased + EXP_IW'(man_inc[`FP_MAN_W]); // rounding carry
    end

    assign exp_biased = exp_unbiased + EXP_IW'(`FP_EXP_BIAS);

    always_comb begin
        result.sign     = sum_stage.sign;
        result.exponent = man_rounded[`FP_MAN_W-1] ? exp_biased[4:0] : 5'd0; // subnormal
        result.fraction = man_rounded[`FP_MAN_W-2:0];
    end

endmodule

// File: design/fma_fp16.sv
// FP16 fused multiply-add a*b+c with one pipeline stage and a registered result
`timescale 1ns/1ps
`include "fma_fp16_config.svh"

module fma_fp16
    import fma_fp16_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  fp16_t   a,
    input  fp16_t   b,
    input  fp16_t   c,
    output logic    out_valid,
    output fp16_t   product
);

    decoded_t                       decoded;
    logic [`FP_MAN_W-1:0]           mantissa_a;
    logic [`FP_MAN_W-1:0]           mantissa_b;
    pp_rows_t                       rows;
    logic [`PROD_W-1:0]             mantissa_product;
    sum_stage_t                     sum_stage_d;
    sum_stage_t                     sum_stage_q;
    logic                           stage_valid;
    logic [`SUM_W-1:0]              normalized;
    logic signed [`FP_EXP_W-1:0]    exp_offset;
    fp16_t                          result;

    // first half: multiply and accumulate
    operand_decode u_decode (
        .a          (a),
        .b          (b),
        .c          (c),
        .decoded    (decoded),
        .mantissa_a (mantissa_a),
        .mantissa_b (mantissa_b)
    );

    booth8_pp_gen u_pp_gen (
        .mantissa_a (mantissa_a),
        .mantissa_b (mantissa_b),
        .rows       (rows)
    );

    csa_reduce u_reduce (
        .rows             (rows),
        .mantissa_product (mantissa_product)
    );

    addend_align u_align (
        .decoded          (decoded),
        .mantissa_product (mantissa_product),
        .sum_stage        (sum_stage_d)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sum_stage_q <= sum_stage_d;
        end
    end

    // second half: normalize, round, pack
    lzc_normalize u_normalize (
        .sum_stage  (sum_stage_q),
        .normalized (normalized),
        .exp_offset (exp_offset)
    );

    round_pack u_round (
        .sum_stage  (sum_stage_q),
        .normalized (normalized),
        .exp_offset (exp_offset),
        .result     (result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin // hold last result otherwise
                product <= result;
            end
        end
    end

endmodule

// File: tb/fma_fp16_tb.sv
// self-checking testbench for the FP16 FMA, applies a table of exact cases with random gaps
`timescale 1ns/1ps

module fma_fp16_tb
    import fma_fp16_pkg::*;
();

    localparam int NUM_VECTORS = 10;
    localparam int CYCLE_LIMIT = 3 + 4 * NUM_VECTORS + 10;

    typedef struct packed {
        fp16_t a;
        fp16_t b;
        fp16_t c;
        fp16_t expected;
    } vector_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    fp16_t      a;
    fp16_t      b;
    fp16_t      c;
    logic       out_valid;
    fp16_t      product;

    vector_t    vectors [NUM_VECTORS];
    int         pending [$];        // entry indices in issue order
    logic [1:0] valid_pipe = '0;    // in_valid seen at the last two rising edges
    int         results_seen = 0;
    int         cycle_count = 0;
    logic [31:0] lcg_state = 32'he835_4077;

    fma_fp16 UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .out_valid (out_valid),
        .product   (product)
    );

    always #10 clk = ~clk;

    // result appears at the second rising edge after issue
    always @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], in_valid};
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: results missing");
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_product(input fp16_t got, input fp16_t expected, input int index);
        if (got !== expected) begin
            $display("FAILED at %0t: entry %0d product %h, expected %h",
                     $time, index, got, expected);
            $display("Simulation failed");
            $fatal(1, "product mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAILED at %0t: out_valid %b, expected %b", $time, got, expected);
            $display("Simulation failed");
            $fatal(1, "out_valid mismatch");
        end
    endtask

    // {a, b, c, expected}
    task automatic load_vectors();
        vectors[0] = {16'h3E00, 16'h4000, 16'h3C00, 16'h4400}; // 1.5*2+1 = 4
        vectors[1] = {16'h4200, 16'h4200, 16'h3800, 16'h48C0}; // 3*3+0.5 = 9.5
        vectors[2] = {16'hC000, 16'h4100, 16'h3C00, 16'hC400}; // -2*2.5+1 = -4
        vectors[3] = {16'h4200, 16'h4200, 16'hC840, 16'h3800}; // 3*3-8.5 = 0.5
        vectors[4] = {16'h3C00, 16'h1400, 16'h6400, 16'h6400}; // far left, c passes
        vectors[5] = {16'h3C00, 16'h3C00, 16'h6800, 16'h6800}; // 2049 tie to 2048
        vectors[6] = {16'h3C00, 16'h4200, 16'h6800, 16'h6802}; // 2051 tie to 2052
        vectors[7] = {16'h0400, 16'h3800, 16'h0000, 16'h0200}; // subnormal result
        vectors[8] = {16'h0001, 16'h6400, 16'h0000, 16'h0400}; // subnormal input
        vectors[9] = {16'h4000, 16'h4000, 16'h4000, 16'h4600}; // 2*2+2 = 6
    endtask

    // one falling edge, then check whatever the DUT presents
    task automatic next_cycle();
        int idx;
        @(negedge clk);
        check_valid(out_valid, valid_pipe[1]);
        if (out_valid) begin
            if (pending.size() == 0) begin
                $display("result arrived with no operation outstanding");
                $display("Simulation failed");
                $fatal(1, "unexpected result");
            end
            idx = pending.pop_front();
            check_product(product, vectors[idx].expected, idx);
            results_seen++;
        end
    endtask

    initial begin
        int idle;
        reset    = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        c        = '0;
        load_vectors();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_valid(out_valid, 1'b0);
        check_product(product, '0, -1);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            idle = (lcg_next() >> 16) % 3; // 0 gives back-to-back issues
            if (i % 3 == 1) begin
                idle = 0; // some pairs always share the pipeline
            end
            repeat (idle) begin
                next_cycle();
                in_valid = 1'b0;
            end
            next_cycle();
            in_valid = 1'b1;
            a        = vectors[i].a;
            b        = vectors[i].b;
            c        = vectors[i].c;
            pending.push_back(i);
        end
        next_cycle();
        in_valid = 1'b0;
        repeat (3) next_cycle(); // drain the two stages

        if (results_seen == NUM_VECTORS && pending.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("got %0d results for %0d issued operations", results_seen, NUM_VECTORS);
            $display("Simulation failed");
            $fatal(1, "result count mismatch");
        end
    end

endmodule

// File: fma_fp16.f
+incdir+include
design/fma_fp16_pkg.sv
design/operand_decode.sv
design/booth8_pp_gen.sv
design/csa_reduce.sv
design/addend_align.sv
design/lzc_normalize.sv
design/round_pack.sv
design/fma_fp16.sv
tb/fma_fp16_tb.sv

// File: Makefile
TOP = fma_fp16_tb

all: run

build:
	verilator --binary --timing -f fma_fp16.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^Simulation passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f fma_fp16.f --top-module fma_fp16

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
